// ==== project.f ====
+incdir+hw
hw/aer_array_pkg.sv
hw/aer_event_pkg.sv
hw/pixel_level.sv
hw/pixel_groups_l0.sv
hw/group_arbiter.sv
hw/timestamp_timer.sv
hw/readout_fsm.sv
hw/aer_readout_top.sv
dv/tb_clock_gen.sv
dv/aer_readout_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the Verilator model of the AER readout testbench and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module aer_readout_tb \
    -o aer_readout_sim

./obj_dir/aer_readout_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    echo "run.sh: simulation did not pass, see sim.log"
    exit 1
fi

// ==== dv/aer_readout_tb.sv ====
`include "aer_config.svh"

module aer_readout_tb;
    import aer_array_pkg::*;
    import aer_event_pkg::*;

    localparam int TS_BITS = `AER_TS_LOW_BITS + `AER_TS_HIGH_BITS;

    logic        clk;
    logic        rst;
    logic        aer_ready;
    logic        aer_valid;
    aer_word_u   aer_word;
    pixel_set_t  latch;            // Pixel latch model that drives the DUT array input
    pixel_set_t  want;             // Pixels set and not yet reported
    pixel_mask_t pixel_ack;

    integer      seed;
    logic        stall_mode;
    int          stretch;
    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;
    string       cur_test;

    aer_event_t                   evt_q[$];
    int                           mark_cnt;
    int                           stall_cnt;
    logic [`AER_TS_HIGH_BITS-1:0] last_mark_high;
    logic [`AER_TS_HIGH_BITS-1:0] ref_high;
    logic [`AER_TS_LOW_BITS-1:0]  last_evt_ts;
    logic [TS_BITS-1:0]           ts_ref;      // Timer value rebuilt from the cycle count
    logic                         stalled;
    aer_word_u                    held_word;
    aer_event_t                   last_evt;    // Event whose pixel awaits its acknowledge
    logic                         ack_due;
    pixel_mask_t                  ack_want;

    tb_clock_gen #(.PERIOD(100)) u_clk (.clk_o(clk));

    aer_readout_top dut0 (
        .clk_i       (clk),
        .rst_i       (rst),
        .pixel_set_i (latch),
        .pixel_ack_o (pixel_ack),
        .aer_word_o  (aer_word),
        .aer_valid_o (aer_valid),
        .aer_ready_i (aer_ready)
    );

    // ------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------
    task record_word;
        if (aer_word.mrk.kind) begin
            ref_high = ts_ref[TS_BITS-1:`AER_TS_LOW_BITS];
            assert (aer_word.mrk.ts_high == ref_high) else begin
                $display("** Error: %s: expected marker ts_high %0d, actual %0d",
                         cur_test, ref_high, aer_word.mrk.ts_high);
                err_cnt++;
            end
            last_mark_high = aer_word.mrk.ts_high;
            last_evt_ts    = '0;
            mark_cnt++;
        end else begin
            assert (aer_word.evt.ts_low >= last_evt_ts) else begin
                $display("** Error: %s: expected ts_low of at least %0d, actual %0d",
                         cur_test, last_evt_ts, aer_word.evt.ts_low);
                err_cnt++;
            end
            assert (!ack_due) else begin
                $display("%s: an event was accepted before the last pixel was acknowledged",
                         cur_test);
                err_cnt++;
            end
            ack_due     = 1'b1;
            last_evt    = aer_word.evt;
            last_evt_ts = aer_word.evt.ts_low;
            evt_q.push_back(aer_word.evt);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ts_ref  = '0;
            stalled = 1'b0;
            ack_due = 1'b0;
        end else begin
            if (stalled) begin
                assert (aer_valid) else begin
                    $display("%s: valid dropped while the port was stalled", cur_test);
                    err_cnt++;
                end
                assert (aer_word == held_word) else begin
                    $display("** Error: %s: expected stalled word %h, actual %h",
                             cur_test, held_word, aer_word);
                    err_cnt++;
                end
            end
            if (pixel_ack != '0) begin
                ack_want = '0;
                if (ack_due) begin
                    ack_want[last_evt.y][last_evt.x] = 1'b1;
                end
                assert (pixel_ack == ack_want) else begin
                    $display("** Error: %s: expected acknowledge mask %h, actual %h",
                             cur_test, ack_want, pixel_ack);
                    err_cnt++;
                end
                ack_due = 1'b0;
            end
            if (aer_valid && aer_ready) begin
                record_word();
            end
            if (aer_valid && !aer_ready) begin
                stall_cnt++;
            end
            stalled   = aer_valid && !aer_ready;
            held_word = aer_word;
            ts_ref    = ts_ref + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Stimulus and pixel model on the falling edge
    // ------------------------------------------------------------
    task next_cycle;
        @(negedge clk);
        for (int r = 0; r < `AER_ARRAY_DIM; r++) begin
            for (int c = 0; c < `AER_ARRAY_DIM; c++) begin
                if (pixel_ack[r][c]) begin
                    latch[r][c] = '0;          // Acknowledge clears both polarities
                end
            end
        end
        if (!stall_mode) begin
            aer_ready = 1'b1;
        end else if (stretch == 0) begin
            aer_ready = !aer_ready;
            stretch   = 1 + ({$random(seed)} % 8);
        end else begin
            stretch = stretch - 1;
        end
    endtask

    task post_pixel(input int x, input int y, input logic [`AER_POL_BITS-1:0] pol);
        latch[y][x] = latch[y][x] | pol;
        want[y][x]  = want[y][x] | pol;
    endtask

    task post_random(input int count);
        int x;
        int y;
        int n;
        n = 0;
        for (int i = 0; i < 1000 && n < count; i++) begin
            x = {$random(seed)} % `AER_ARRAY_DIM;
            y = {$random(seed)} % `AER_ARRAY_DIM;
            if (want[y][x] == '0) begin
                post_pixel(x, y, `AER_POL_BITS'(1 + {$random(seed)} % 3));
                n++;
            end
        end
    endtask

    task wait_drain(input int limit);
        int i;
        i = 0;
        while (latch != '0 && i < limit) begin
            next_cycle();
            i++;
        end
        assert (latch == '0) else begin
            $display("%s: timed out with pixels still latched", cur_test);
            err_cnt++;
        end
    endtask

    task wait_valid(input int limit);
        int i;
        i = 0;
        while (!aer_valid && i < limit) begin
            next_cycle();
            i++;
        end
        assert (aer_valid) else begin
            $display("%s: timed out waiting for an output word", cur_test);
            err_cnt++;
        end
    endtask

    task wait_marker(input int count, input int limit);
        int i;
        i = 0;
        while (mark_cnt < count && i < limit) begin
            next_cycle();
            i++;
        end
        assert (mark_cnt >= count) else begin
            $display("%s: timed out waiting for a time marker", cur_test);
            err_cnt++;
        end
    endtask

    task check_events;
        aer_event_t e;
        foreach (evt_q[i]) begin
            e = evt_q[i];
            assert (want[e.y][e.x] == e.pol) else begin
                $display("** Error: %s: pixel (%0d,%0d) expected pol %b, actual %b",
                         cur_test, e.x, e.y, want[e.y][e.x], e.pol);
                err_cnt++;
            end
            want[e.y][e.x] = '0;               // A second report of this pixel fails
        end
        assert (want == '0) else begin
            $display("%s: pixels were set but never reported", cur_test);
            err_cnt++;
        end
    endtask

    task start_test(input string name);
        cur_test = name;
        err_mark = err_cnt;
        want     = '0;
        evt_q.delete();
    endtask

    task finish_test;
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("%s: passed", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", cur_test, err_cnt - err_mark);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task test_single_event;
        start_test("single_event");
        next_cycle();
        post_pixel(5, 2, 2'b01);
        wait_drain(200);
        assert (evt_q.size() == 1) else begin
            $display("** Error: %s: expected 1 word, actual %0d", cur_test, evt_q.size());
            err_cnt++;
        end
        check_events();
        finish_test();
    endtask

    task test_group_burst;
        int first_late;
        int last_early;
        start_test("group_burst");
        next_cycle();
        post_pixel(0, 0, 2'b01);
        post_pixel(1, 0, 2'b10);
        post_pixel(3, 1, 2'b11);
        post_pixel(2, 2, 2'b01);
        post_pixel(0, 3, 2'b10);
        post_pixel(3, 3, 2'b01);
        wait_valid(100);
        next_cycle();
        post_pixel(4, 4, 2'b10);               // Lower right group is set while group 0 runs
        post_pixel(6, 5, 2'b01);
        post_pixel(7, 7, 2'b11);
        wait_drain(500);
        check_events();
        first_late = evt_q.size();
        last_early = -1;
        foreach (evt_q[i]) begin
            if (evt_q[i].x >= `AER_GROUP_DIM) begin
                if (i < first_late) begin
                    first_late = i;
                end
            end else begin
                last_early = i;
            end
        end
        assert (last_early < first_late) else begin
            $display("%s: a later group was read before the first group drained", cur_test);
            err_cnt++;
        end
        finish_test();
    endtask

    task test_random_scatter;
        start_test("random_scatter");
        next_cycle();
        post_random(12);
        wait_drain(1000);
        check_events();
        finish_test();
    endtask

    task test_back_pressure;
        start_test("back_pressure");
        next_cycle();
        post_random(10);
        stall_cnt  = 0;
        stretch    = 0;
        stall_mode = 1'b1;
        wait_drain(3000);
        stall_mode = 1'b0;
        check_events();
        assert (stall_cnt > 0) else begin
            $display("%s: the output port was never stalled", cur_test);
            err_cnt++;
        end
        finish_test();
    endtask

    task test_markers;
        int                           marks;
        logic [`AER_TS_HIGH_BITS-1:0] high0;
        start_test("timestamp_markers");
        marks = mark_cnt;
        high0 = last_mark_high;
        next_cycle();
        post_pixel(1, 6, 2'b10);
        post_pixel(6, 1, 2'b01);
        wait_drain(200);
        wait_marker(marks + 1, 2 << `AER_TS_LOW_BITS);
        next_cycle();
        post_pixel(3, 3, 2'b11);
        post_pixel(7, 0, 2'b01);
        post_pixel(2, 5, 2'b10);
        wait_drain(300);
        check_events();
        assert (mark_cnt == marks + 1) else begin
            $display("** Error: %s: expected %0d markers, actual %0d",
                     cur_test, marks + 1, mark_cnt);
            err_cnt++;
        end
        assert (last_mark_high == high0 + 1'b1) else begin
            $display("** Error: %s: expected marker ts_high %0d, actual %0d",
                     cur_test, high0 + 1'b1, last_mark_high);
            err_cnt++;
        end
        finish_test();
    endtask

    initial begin
        seed           = 31119;
        rst            = 1'b1;
        aer_ready      = 1'b1;
        latch          = '0;
        want           = '0;
        stall_mode     = 1'b0;
        stretch        = 0;
        err_cnt        = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        mark_cnt       = 0;
        stall_cnt      = 0;
        last_mark_high = '0;
        last_evt_ts    = '0;
        ack_due        = 1'b0;
        cur_test       = "reset";
        repeat (16) next_cycle();
        rst = 1'b0;

        test_single_event();
        test_group_burst();
        test_random_scatter();
        test_back_pressure();
        test_markers();

        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

// ==== hw/aer_readout_top.sv ====
`include "aer_config.svh"

module aer_readout_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  aer_array_pkg::pixel_set_t  pixel_set_i,
    output aer_array_pkg::pixel_mask_t pixel_ack_o,
    output aer_event_pkg::aer_word_u   aer_word_o,
    output logic                       aer_valid_o,
    input  logic                       aer_ready_i
);
    import aer_array_pkg::*;

    group_mask_t                   req_group;
    group_mask_t                   gnt_group;
    logic                          grp_release;
    logic                          pix_valid;
    pixel_addr_t                   pix_addr;
    logic [`AER_POL_BITS-1:0]      pix_pol;
    logic                          pix_ack;
    logic [`AER_TS_LOW_BITS-1:0]   ts_low;
    logic [`AER_TS_HIGH_BITS-1:0]  ts_high;
    logic                          marker_pend;
    logic                          marker_take;

    pixel_groups_l0 u_groups (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .set_i         (pixel_set_i),
        .gnt_top_i     (gnt_group),
        .ack_i         (pix_ack),
        .req_o         (req_group),
        .pixel_ack_o   (pixel_ack_o),
        .pix_valid_o   (pix_valid),
        .pix_addr_o    (pix_addr),
        .pix_pol_o     (pix_pol),
        .grp_release_o (grp_release)
    );

    group_arbiter u_group_arb (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req_group),
        .release_i (grp_release),
        .gnt_o     (gnt_group)
    );

    timestamp_timer u_timer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .take_i        (marker_take),
        .ts_low_o      (ts_low),
        .ts_high_o     (ts_high),
        .marker_pend_o (marker_pend)
    );

    readout_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .pix_valid_i   (pix_valid),
        .pix_addr_i    (pix_addr),
        .pix_pol_i     (pix_pol),
        .ts_low_i      (ts_low),
        .ts_high_i     (ts_high),
        .marker_pend_i (marker_pend),
        .marker_take_o (marker_take),
        .pix_ack_o     (pix_ack),
        .aer_word_o    (aer_word_o),
        .aer_valid_o   (aer_valid_o),
        .aer_ready_i   (aer_ready_i)
    );

endmodule

// ==== hw/readout_fsm.sv ====
`include "aer_config.svh"

module readout_fsm (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          pix_valid_i,
    input  aer_array_pkg::pixel_addr_t    pix_addr_i,
    input  logic [`AER_POL_BITS-1:0]      pix_pol_i,
    input  logic [`AER_TS_LOW_BITS-1:0]   ts_low_i,
    input  logic [`AER_TS_HIGH_BITS-1:0]  ts_high_i,
    input  logic                          marker_pend_i,
    output logic                          marker_take_o,
    output logic                          pix_ack_o,
    output aer_event_pkg::aer_word_u      aer_word_o,
    output logic                          aer_valid_o,
    input  logic                          aer_ready_i
);
    import aer_event_pkg::*;

    readout_state_e state_q;
    aer_word_u      word_next;

    // ------------------------------------------------------------
    // Word build with the marker view ahead of the event view
    // ------------------------------------------------------------
    always_comb begin
        word_next = '0;
        if (marker_pend_i) begin
            word_next.mrk.kind    = 1'b1;
            word_next.mrk.rsvd    = '0;
            word_next.mrk.ts_high = ts_high_i;
        end else begin
            word_next.evt.kind   = 1'b0;
            word_next.evt.x      = pix_addr_i.x;
            word_next.evt.y      = pix_addr_i.y;
            word_next.evt.pol    = pix_pol_i;
            word_next.evt.ts_low = ts_low_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            aer_word_o <= word_next;              // Frozen once the word is presented
        end
    end

    // ------------------------------------------------------------
    // State sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (marker_pend_i) begin
                        state_q <= MARK;
                    end else if (pix_valid_i) begin
                        state_q <= EVENT;
                    end
                end
                MARK: begin
                    if (aer_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                EVENT: begin
                    if (aer_ready_i) begin
                        state_q <= ACK;
                    end
                end
                ACK:     state_q <= IDLE;         // Latch clears at the end of this cycle
                default: state_q <= IDLE;
            endcase
        end
    end

    assign marker_take_o = (state_q == IDLE) && marker_pend_i;
    assign aer_valid_o   = (state_q == MARK) || (state_q == EVENT);
    assign pix_ack_o     = (state_q == ACK);

    a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        aer_valid_o && !aer_ready_i |=> aer_valid_o && $stable(aer_word_o))
        else $error("readout_fsm output word changed while stalled");

endmodule

// ==== hw/timestamp_timer.sv ====
`include "aer_config.svh"

module timestamp_timer (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          take_i,
    output logic [`AER_TS_LOW_BITS-1:0]   ts_low_o,
    output logic [`AER_TS_HIGH_BITS-1:0]  ts_high_o,
    output logic                          marker_pend_o
);
    logic wrap;

    assign wrap = &ts_low_o;            // Next edge rolls the low word over

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ts_low_o  <= '0;
            ts_high_o <= '0;
        end else begin
            ts_low_o <= ts_low_o + 1'b1;
            if (wrap) begin
                ts_high_o <= ts_high_o + 1'b1;
            end
        end
    end

    // A new wrap wins over a take in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            marker_pend_o <= 1'b0;
        end else if (wrap) begin
            marker_pend_o <= 1'b1;
        end else if (take_i) begin
            marker_pend_o <= 1'b0;
        end
    end

endmodule

// ==== hw/group_arbiter.sv ====
`include "aer_config.svh"

module group_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  aer_array_pkg::group_mask_t req_i,
    input  logic                       release_i,
    output aer_array_pkg::group_mask_t gnt_o
);
    import aer_array_pkg::*;

    localparam int NG       = `AER_NUM_GROUPS;
    localparam int PTR_BITS = $clog2(NG);

    logic [NG-1:0]       req_flat;
    logic [PTR_BITS-1:0] last_q;       // Group granted most recently
    logic [PTR_BITS-1:0] pick_idx;
    logic                pick_found;
    group_mask_t         gnt_next;

    assign req_flat = req_i;

    always_comb begin
        logic [PTR_BITS-1:0] idx;
        idx        = '0;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = 1; i <= NG; i++) begin
            idx = PTR_BITS'((int'(last_q) + i) % NG);
            if (!pick_found && req_flat[idx]) begin
                pick_found = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    assign gnt_next = group_mask_t'(NG'(1) << pick_idx);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_o  <= '0;
            last_q <= PTR_BITS'(NG - 1);
        end else if (gnt_o != '0) begin
            if (release_i) begin
                gnt_o <= '0;                   // Group has drained
            end
        end else if (pick_found) begin
            gnt_o  <= gnt_next;
            last_q <= pick_idx;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_o))
        else $error("group_arbiter grant is not one-hot");

endmodule

// ==== hw/pixel_groups_l0.sv ====
`include "aer_config.svh"

module pixel_groups_l0 (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  aer_array_pkg::pixel_set_t  set_i,
    input  aer_array_pkg::group_mask_t gnt_top_i,
    input  logic                       ack_i,
    output aer_array_pkg::group_mask_t req_o,
    output aer_array_pkg::pixel_mask_t pixel_ack_o,
    output logic                       pix_valid_o,
    output aer_array_pkg::pixel_addr_t pix_addr_o,
    output logic [`AER_POL_BITS-1:0]   pix_pol_o,
    output logic                       grp_release_o
);
    import aer_array_pkg::*;

    localparam int GDIM = `AER_GROUP_DIM;
    localparam int GPS  = `AER_GROUPS_PER_SIDE;
    localparam int NG   = `AER_NUM_GROUPS;

    pixel_addr_t [NG-1:0]                     addr_grp;
    logic        [NG-1:0][`AER_POL_BITS-1:0]  pol_grp;
    logic        [NG-1:0]                     active_grp;
    logic        [NG-1:0]                     release_grp;

    // ------------------------------------------------------------
    // One level-0 arbiter per group
    // ------------------------------------------------------------
    for (genvar g = 0; g < NG; g++) begin : g_group
        localparam int GR = g / GPS;
        localparam int GC = g % GPS;
        localparam logic [`AER_ADDR_BITS-1:0] BASE_ROW = `AER_ADDR_BITS'(GR * GDIM);
        localparam logic [`AER_ADDR_BITS-1:0] BASE_COL = `AER_ADDR_BITS'(GC * GDIM);

        logic [GDIM-1:0][GDIM-1:0][`AER_POL_BITS-1:0] set_local;
        logic [GDIM-1:0][GDIM-1:0]                    gnt_local;
        logic [`AER_ADDR_BITS-1:0]                    x_local;
        logic [`AER_ADDR_BITS-1:0]                    y_local;

        for (genvar r = 0; r < GDIM; r++) begin : g_row
            for (genvar c = 0; c < GDIM; c++) begin : g_col
                assign set_local[r][c] = set_i[GR*GDIM + r][GC*GDIM + c];
                assign pixel_ack_o[GR*GDIM + r][GC*GDIM + c] = gnt_local[r][c] & ack_i;
            end
        end

        pixel_level #(
            .GROUP_SIZE (GDIM),
            .ADDR_BITS  (`AER_ADDR_BITS)
        ) u_pixel_level (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .enable_i      (gnt_top_i[GR][GC]),
            .req_i         (set_local),
            .ack_i         (ack_i),
            .req_o         (req_o[GR][GC]),
            .gnt_o         (gnt_local),
            .x_add_o       (x_local),
            .y_add_o       (y_local),
            .pol_o         (pol_grp[g]),
            .active_o      (active_grp[g]),
            .grp_release_o (release_grp[g])
        );

        assign addr_grp[g].x = BASE_COL + x_local;   // Local to array address
        assign addr_grp[g].y = BASE_ROW + y_local;
    end

    // Only the group granted at the top reaches the readout
    always_comb begin
        pix_valid_o   = 1'b0;
        pix_addr_o    = '0;
        pix_pol_o     = '0;
        grp_release_o = 1'b0;
        for (int g = 0; g < NG; g++) begin
            if (gnt_top_i[g / GPS][g % GPS]) begin
                pix_valid_o   = active_grp[g];
                pix_addr_o    = addr_grp[g];
                pix_pol_o     = pol_grp[g];
                grp_release_o = release_grp[g];
            end
        end
    end

endmodule

// ==== hw/pixel_level.sv ====
`include "aer_config.svh"

module pixel_level #(
    parameter int GROUP_SIZE = 4,
    parameter int ADDR_BITS  = 3
) (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    input  logic                                              enable_i,
    input  logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0][`AER_POL_BITS-1:0] req_i,
    input  logic                                              ack_i,
    output logic                                              req_o,
    output logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0]             gnt_o,
    output logic [ADDR_BITS-1:0]                              x_add_o,
    output logic [ADDR_BITS-1:0]                              y_add_o,
    output logic [`AER_POL_BITS-1:0]                          pol_o,
    output logic                                              active_o,
    output logic                                              grp_release_o
);
    localparam int NUM_PIX  = GROUP_SIZE * GROUP_SIZE;
    localparam int IDX_BITS = $clog2(NUM_PIX);

    logic [NUM_PIX-1:0]  req_flat;   // Index is row * GROUP_SIZE + col
    logic [NUM_PIX-1:0]  gnt_q;
    logic [IDX_BITS-1:0] ptr_q;      // Last pixel served
    logic [IDX_BITS-1:0] gnt_idx_q;
    logic [IDX_BITS-1:0] next_idx;
    logic                next_found;

    always_comb begin
        for (int r = 0; r < GROUP_SIZE; r++) begin
            for (int c = 0; c < GROUP_SIZE; c++) begin
                req_flat[r*GROUP_SIZE + c] = |req_i[r][c];
            end
        end
    end

    // Search starts one past the last served pixel
    always_comb begin
        logic [IDX_BITS-1:0] idx;
        idx        = '0;
        next_found = 1'b0;
        next_idx   = '0;
        for (int i = 1; i <= NUM_PIX; i++) begin
            idx = IDX_BITS'((int'(ptr_q) + i) % NUM_PIX);
            if (!next_found && req_flat[idx]) begin
                next_found = 1'b1;
                next_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_q <= '0;
            ptr_q <= IDX_BITS'(NUM_PIX - 1);
        end else if (!enable_i || ack_i) begin
            gnt_q <= '0;                       // Gap cycle lets the cleared latch settle
        end else if (gnt_q == '0 && next_found) begin
            gnt_q <= NUM_PIX'(1) << next_idx;
            ptr_q <= next_idx;
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt_q == '0 && next_found) begin
            gnt_idx_q <= next_idx;
        end
    end

    assign gnt_o         = gnt_q;
    assign req_o         = |req_flat;
    assign active_o      = |gnt_q;
    assign grp_release_o = enable_i && !active_o && !req_o;
    assign x_add_o       = ADDR_BITS'(gnt_idx_q % GROUP_SIZE);
    assign y_add_o       = ADDR_BITS'(gnt_idx_q / GROUP_SIZE);
    assign pol_o         = req_i[gnt_idx_q / GROUP_SIZE][gnt_idx_q % GROUP_SIZE];

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_q))
        else $error("pixel_level grant is not one-hot");

endmodule

// ==== hw/aer_event_pkg.sv ====
`include "aer_config.svh"

package aer_event_pkg;

    typedef struct packed {
        logic                         kind;     // Always 0 for an event
        logic [`AER_ADDR_BITS-1:0]    x;
        logic [`AER_ADDR_BITS-1:0]    y;
        logic [`AER_POL_BITS-1:0]     pol;
        logic [`AER_TS_LOW_BITS-1:0]  ts_low;
    } aer_event_t;

    typedef struct packed {
        logic                                          kind;    // Always 1 for a marker
        logic [`AER_WORD_BITS-`AER_TS_HIGH_BITS-2:0]   rsvd;
        logic [`AER_TS_HIGH_BITS-1:0]                  ts_high;
    } aer_marker_t;

    // The kind bit sits at the top of both views and selects the decode
    typedef union packed {
        aer_event_t  evt;
        aer_marker_t mrk;
    } aer_word_u;

    typedef enum logic [1:0] {
        IDLE,
        MARK,
        EVENT,
        ACK
    } readout_state_e;

endpackage

// ==== hw/aer_array_pkg.sv ====
`include "aer_config.svh"

package aer_array_pkg;

    // Latch bits of the whole array are indexed [row][col][pol]
    typedef logic [`AER_ARRAY_DIM-1:0][`AER_ARRAY_DIM-1:0][`AER_POL_BITS-1:0] pixel_set_t;

    // One bit per pixel serves grant and acknowledge
    typedef logic [`AER_ARRAY_DIM-1:0][`AER_ARRAY_DIM-1:0] pixel_mask_t;

    // Group bits are indexed [group row][group col]
    typedef logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] group_mask_t;

    // x is the column and y is the row
    typedef struct packed {
        logic [`AER_ADDR_BITS-1:0] x;
        logic [`AER_ADDR_BITS-1:0] y;
    } pixel_addr_t;

endpackage

// ==== hw/aer_config.svh ====
`ifndef AER_CONFIG_SVH
`define AER_CONFIG_SVH

// ------------------------------------------------------------
// Pixel array geometry
// ------------------------------------------------------------
`define AER_ARRAY_DIM        8
`define AER_GROUP_DIM        4
`define AER_GROUPS_PER_SIDE  (`AER_ARRAY_DIM / `AER_GROUP_DIM)
`define AER_NUM_GROUPS       (`AER_GROUPS_PER_SIDE * `AER_GROUPS_PER_SIDE)
`define AER_ADDR_BITS        3
`define AER_POL_BITS         2     // On and off latch per pixel

// Timestamp and output word widths
`define AER_TS_LOW_BITS      15
`define AER_TS_HIGH_BITS     16
`define AER_WORD_BITS        (1 + 2 * `AER_ADDR_BITS + `AER_POL_BITS + `AER_TS_LOW_BITS)

`endif
